// File: build.f
+incdir+testbench
verilog/fp_pkg.sv
verilog/apb_pkg.sv
verilog/mant_mul.sv
verilog/exp_calc.sv
verilog/norm_pack.sv
verilog/fpmul_core.sv
verilog/apb_regs.sv
verilog/fpmul_apb_top.sv
testbench/tb_fpmul.sv

// File: testbench/fp_model.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

function automatic fp32_t make_fp(input logic sign, input logic [EXP_W-1:0] exp,
		input logic [FRAC_W-1:0] frac);
	fp32_t w;
	w.sign = sign;
	w.exp  = exp;
	w.frac = frac;
	return w;
endfunction

// expected product, zero exponent fields flush to zero and the fraction is truncated
function automatic mul_res_t model_mul(input fp32_t a, input fp32_t b);
	mul_res_t    r;
	logic [63:0] prod;
	int          exp_val;
	r = '0;
	r.word.sign = a.sign ^ b.sign;
	if (a.exp == 0 || b.exp == 0)
		return r;
	prod    = {40'd0, 1'b1, a.frac} * {40'd0, 1'b1, b.frac};
	exp_val = int'(a.exp) + int'(b.exp) - EXP_BIAS;
	if (prod[47]) begin
		exp_val++;   // product in [2,4), move the point one place left
		r.word.frac = prod[46:24];
	end else begin
		r.word.frac = prod[45:23];
	end
	if (exp_val >= EXP_MAX) begin
		r.word.exp  = EXP_W'(EXP_MAX);
		r.word.frac = '0;
		r.ovf       = 1'b1;
	end else if (exp_val <= 0) begin
		r.word.frac = '0;
		r.unf       = 1'b1;
	end else begin
		r.word.exp = EXP_W'(exp_val);
	end
	return r;
endfunction

// status word once a product has finished
function automatic logic [DATA_W-1:0] model_status(input mul_res_t r);
	logic [DATA_W-1:0] s;
	s            = '0;
	s[STAT_DONE] = 1'b1;
	s[STAT_OVF]  = r.ovf;
	s[STAT_UNF]  = r.unf;
	return s;
endfunction

`endif

// File: testbench/tb_fpmul.sv
`timescale 1ns/10ps
module tb_fpmul import fp_pkg::*, apb_pkg::*; ();
	localparam int N_RAND      = 40;
	localparam int N_OPS       = N_RAND + 20;   // random products plus directed transfers
	localparam int CYCLE_LIMIT = N_OPS * 200 + 400;

	logic              clk;
	logic              arst_n;
	apb_req_t          req;
	apb_rsp_t          rsp;
	integer            seed;
	int                errors;
	int                checks;
	int                cycles;
	logic [DATA_W-1:0] rd;
	logic              err;
	fp32_t             a;
	fp32_t             b;
	fp32_t             a_late;
	mul_res_t          expect_res;

	`include "fp_model.svh"

	fpmul_apb_top fpmul_apb_top_i (.clk(clk), .arst_n(arst_n), .apb_req(req), .apb_rsp(rsp));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// with chain set the bus goes straight into the next setup cycle
	task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input bit chain,
			output logic [DATA_W-1:0] rdata, output logic slverr);
		apb_req_t r;
		r        = '0;
		r.psel   = 1'b1;
		r.pwrite = wr;
		r.paddr  = addr;
		r.pwdata = wdata;
		@(posedge clk);
		req <= r;
		@(posedge clk);
		req.penable <= 1'b1;
		@(negedge clk);   // access cycle, response is settled here
		rdata  = rsp.prdata;
		slverr = rsp.pslverr;
		check_value("pready", 32'd1, rsp.pready);   // the slave never inserts wait states
		if (!chain) begin
			@(posedge clk);
			req <= '0;
		end
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input bit chain);
		logic [DATA_W-1:0] unused;
		logic              e;
		apb_xfer(1'b1, addr, data, chain, unused, e);
		check_value("write pslverr", 32'd0, e);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		logic e;
		apb_xfer(1'b0, addr, '0, 1'b0, data, e);
		check_value("read pslverr", 32'd0, e);
	endtask

	task automatic wait_done(input string name);
		logic [DATA_W-1:0] st;
		int                polls;
		st    = '0;
		polls = 0;
		while (!st[STAT_DONE] && polls < 20) begin
			apb_read(REG_STATUS, st);
			polls++;
		end
		if (!st[STAT_DONE]) begin
			errors++;
			$display("%s: status never showed done after %0d polls", name, polls);
		end
	endtask

	task automatic run_mul(input string name, input fp32_t x, input fp32_t y);
		mul_res_t          m;
		logic [DATA_W-1:0] data;
		m = model_mul(x, y);
		apb_write(REG_OP_A, x, 1'b0);
		apb_write(REG_OP_B, y, 1'b0);
		apb_write(REG_CTRL, 32'h1, 1'b0);
		wait_done(name);
		apb_read(REG_RESULT, data);
		check_value(name, m.word, data);
		apb_read(REG_STATUS, data);
		check_value({name, " status"}, model_status(m), data);
	endtask

	function automatic fp32_t rand_operand();
		logic [31:0] rnd;
		fp32_t       w;
		rnd    = $random(seed);
		w.sign = rnd[31];
		w.frac = rnd[FRAC_W-1:0];
		rnd    = $random(seed);
		w.exp  = EXP_W'(32'd1 + rnd % 32'd254);   // normal range only
		return w;
	endfunction

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not complete within %0d cycles", CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		seed   = 32'hfcc6b08c;
		errors = 0;
		checks = 0;
		req    = '0;
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		apb_write(REG_OP_A, 32'h1234_5678, 1'b0);
		apb_write(REG_OP_B, 32'h9abc_def0, 1'b0);
		apb_read(REG_OP_A, rd);
		check_value("op_a readback", 32'h1234_5678, rd);
		apb_read(REG_OP_B, rd);
		check_value("op_b readback", 32'h9abc_def0, rd);
		apb_read(REG_CTRL, rd);
		check_value("ctrl readback", 32'd0, rd);
		apb_xfer(1'b0, 5'h14, '0, 1'b0, rd, err);
		check_value("unmapped read pslverr", 32'd1, err);
		apb_xfer(1'b1, REG_RESULT, 32'hffff_ffff, 1'b0, rd, err);
		check_value("result write pslverr", 32'd1, err);
		apb_xfer(1'b1, REG_STATUS, 32'hffff_ffff, 1'b0, rd, err);
		check_value("status write pslverr", 32'd1, err);

		run_mul("1.5 x 1.5", 32'h3fc0_0000, 32'h3fc0_0000);   // carry into bit 47
		run_mul("1.0 x 1.0", 32'h3f80_0000, 32'h3f80_0000);
		run_mul("-3.0 x 0.75", 32'hc040_0000, 32'h3f40_0000);
		run_mul("zero a", make_fp(1'b1, 8'd0, 23'h12_3456), 32'h3f80_0000);
		run_mul("zero b", make_fp(1'b0, 8'd90, 23'h7), make_fp(1'b1, 8'd0, 23'h0));
		run_mul("overflow", make_fp(1'b0, 8'd200, 23'h1), make_fp(1'b1, 8'd190, 23'h2));
		run_mul("overflow by carry", make_fp(1'b0, 8'd190, 23'h40_0000),
			make_fp(1'b0, 8'd191, 23'h40_0000));
		run_mul("underflow", make_fp(1'b0, 8'd10, 23'h5), make_fp(1'b0, 8'd20, 23'h6));
		run_mul("underflow edge", make_fp(1'b1, 8'd64, 23'h0), make_fp(1'b0, 8'd63, 23'h0));

		for (int i = 0; i < N_RAND; i++) begin
			a = rand_operand();
			b = rand_operand();
			run_mul("random", a, b);
		end

		// operand A changes and a second start arrives before the first product is stored
		a      = rand_operand();
		b      = rand_operand();
		a.exp  = EXP_W'(EXP_BIAS);   // a normal product keeps the fraction of A visible
		b.exp  = EXP_W'(EXP_BIAS);
		a_late = make_fp(a.sign, a.exp, ~a.frac);
		expect_res = model_mul(a, b);
		apb_write(REG_OP_A, a, 1'b0);
		apb_write(REG_OP_B, b, 1'b0);
		apb_write(REG_CTRL, 32'h1, 1'b1);
		apb_write(REG_OP_A, a_late, 1'b1);
		apb_write(REG_CTRL, 32'h1, 1'b0);
		wait_done("start while busy");
		apb_read(REG_RESULT, rd);
		check_value("start while busy", expect_res.word, rd);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: verilog/apb_pkg.sv
package apb_pkg;

	localparam int ADDR_W = 5;
	localparam int DATA_W = 32;

	// register map, word aligned
	localparam logic [ADDR_W-1:0] REG_OP_A   = 5'h00;
	localparam logic [ADDR_W-1:0] REG_OP_B   = 5'h04;
	localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
	localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;

	// bit positions inside REG_STATUS
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;
	localparam int STAT_OVF  = 2;
	localparam int STAT_UNF  = 3;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

endpackage

// File: verilog/apb_regs.sv
`timescale 1ns/10ps
module apb_regs import fp_pkg::*, apb_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic     start,
	output fp32_t    op_a,
	output fp32_t    op_b,
	input  logic     done,
	input  mul_res_t res
);
	logic              access;
	logic              wr_en;
	logic              wr_ro;
	logic              addr_ok;
	logic              start_req;
	logic              busy;
	logic              stat_done;
	logic              stat_ovf;
	logic              stat_unf;
	fp32_t             result;
	logic [DATA_W-1:0] status;
	logic [DATA_W-1:0] rdata;

	assign access = apb_req.psel & apb_req.penable;   // access phase of a transfer
	assign wr_en  = access & apb_req.pwrite;
	assign wr_ro  = (apb_req.paddr == REG_STATUS) | (apb_req.paddr == REG_RESULT);

	// a start while the core is busy is dropped without an error
	assign start_req = wr_en & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0] & ~busy;

	always_comb begin
		status            = '0;
		status[STAT_BUSY] = busy;
		status[STAT_DONE] = stat_done;
		status[STAT_OVF]  = stat_ovf;
		status[STAT_UNF]  = stat_unf;
	end

	always_comb begin
		addr_ok = 1'b1;
		case (apb_req.paddr)
			REG_OP_A:   rdata = op_a;
			REG_OP_B:   rdata = op_b;
			REG_CTRL:   rdata = '0;   // control is write only
			REG_STATUS: rdata = status;
			REG_RESULT: rdata = result;
			default: begin
				rdata   = '0;
				addr_ok = 1'b0;
			end
		endcase
	end

	assign apb_rsp.prdata  = rdata;
	assign apb_rsp.pready  = 1'b1;   // no wait states
	assign apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & wr_ro));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_a <= '0;
			op_b <= '0;
		end else if (wr_en) begin
			if (apb_req.paddr == REG_OP_A)
				op_a <= fp32_t'(apb_req.pwdata);
			if (apb_req.paddr == REG_OP_B)
				op_b <= fp32_t'(apb_req.pwdata);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			start     <= 1'b0;
			busy      <= 1'b0;
			stat_done <= 1'b0;
			stat_ovf  <= 1'b0;
			stat_unf  <= 1'b0;
			result    <= '0;
		end else begin
			start <= start_req;
			if (start_req) begin
				busy      <= 1'b1;
				stat_done <= 1'b0;
				stat_ovf  <= 1'b0;
				stat_unf  <= 1'b0;
			end else if (done) begin
				busy      <= 1'b0;
				stat_done <= 1'b1;
				stat_ovf  <= res.ovf;
				stat_unf  <= res.unf;
				result    <= res.word;
			end
		end
	end

	// only one product in flight, so a start never follows a busy cycle
	a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !$past(busy));
	// the core only answers a start that this block issued
	a_done_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> busy);

endmodule

// File: verilog/exp_calc.sv
`timescale 1ns/10ps
module exp_calc import fp_pkg::*; (
	input  fp32_t    a,
	input  fp32_t    b,
	output exp_sum_t sum
);
	logic              a_zero;
	logic              b_zero;
	logic [ESUM_W-1:0] exp_a;
	logic [ESUM_W-1:0] exp_b;
	logic [ESUM_W-1:0] bias;

	// denormals are flushed, so a zero exponent field means a zero operand
	assign a_zero = (a.exp == '0);
	assign b_zero = (b.exp == '0);

	assign exp_a = ESUM_W'(a.exp);   // zero extended, both fields are unsigned
	assign exp_b = ESUM_W'(b.exp);
	assign bias  = ESUM_W'(EXP_BIAS);

	assign sum.sign = a.sign ^ b.sign;
	assign sum.zero = a_zero | b_zero;

	// one bias too many after the addition, the result may go negative
	assign sum.exp  = exp_a + exp_b - bias;

endmodule

// File: verilog/fp_pkg.sv
package fp_pkg;

	// IEEE 754 single precision field widths
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;
	localparam int MANT_W   = FRAC_W + 1;   // hidden one in front of the fraction
	localparam int PROD_W   = 2 * MANT_W;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;          // exponent field of an infinity

	// width of the signed exponent sum, holds -126 up to 383 plus the normalization step
	localparam int ESUM_W   = EXP_W + 2;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp32_t;

	// exp is two's complement, read it through $signed
	typedef struct packed {
		logic              sign;
		logic              zero;   // one of the operands has exponent field zero
		logic [ESUM_W-1:0] exp;
	} exp_sum_t;

	typedef struct packed {
		fp32_t word;
		logic  ovf;
		logic  unf;
	} mul_res_t;

endpackage

// File: verilog/fpmul_apb_top.sv
`timescale 1ns/10ps
module fpmul_apb_top import fp_pkg::*, apb_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);
	logic     start;
	logic     done;
	fp32_t    op_a;
	fp32_t    op_b;
	mul_res_t res;

	apb_regs apb_regs_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.start   (start),
		.op_a    (op_a),
		.op_b    (op_b),
		.done    (done),
		.res     (res)
	);

	fpmul_core fpmul_core_i (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.op_a   (op_a),
		.op_b   (op_b),
		.done   (done),
		.res    (res)
	);

endmodule

// File: verilog/fpmul_core.sv
`timescale 1ns/10ps
module fpmul_core import fp_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     start,
	input  fp32_t    op_a,
	input  fp32_t    op_b,
	output logic     done,
	output mul_res_t res
);
	exp_sum_t          sum0;
	exp_sum_t          sum1;
	exp_sum_t          sum2;
	logic              v1;
	logic              v2;
	logic              v3;
	logic [FRAC_W-1:0] frac_a1;
	logic [FRAC_W-1:0] frac_b1;
	logic [MANT_W-1:0] mant_a;
	logic [MANT_W-1:0] mant_b;
	logic [PROD_W-1:0] prod0;
	logic [PROD_W-1:0] prod2;
	mul_res_t          res0;
	mul_res_t          res3;

	exp_calc exp_calc_i (.a(op_a), .b(op_b), .sum(sum0));

	// hidden one comes back only for nonzero operands
	assign mant_a = {~sum1.zero, frac_a1};
	assign mant_b = {~sum1.zero, frac_b1};

	mant_mul #(.WIDTH(MANT_W)) mant_mul_i (.x(mant_a), .y(mant_b), .p(prod0));

	norm_pack norm_pack_i (.prod(prod2), .sum(sum2), .res(res0));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			v3 <= v2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frac_a1 <= '0;
			frac_b1 <= '0;
			sum1    <= '0;
			prod2   <= '0;
			sum2    <= '0;
			res3    <= '0;
		end else begin
			frac_a1 <= op_a.frac;   // stage 1
			frac_b1 <= op_b.frac;
			sum1    <= sum0;
			prod2   <= prod0;       // stage 2
			sum2    <= sum1;
			res3    <= res0;        // stage 3
		end
	end

	assign done = v3;
	assign res  = res3;

	// fixed latency, the pipeline never stalls
	a_lat_fwd: assert property (@(posedge clk) disable iff (!arst_n) start |-> ##3 done);
	a_lat_bwd: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(start, 3));

endmodule

// File: verilog/mant_mul.sv
`timescale 1ns/10ps
module mant_mul import fp_pkg::*; #(
	parameter int WIDTH = MANT_W
) (
	input  logic [WIDTH-1:0]   x,
	input  logic [WIDTH-1:0]   y,
	output logic [2*WIDTH-1:0] p
);

	generate
		if (WIDTH > 6) begin : g_split
			// half width, rounded up so that odd widths split as well
			localparam int HW = (WIDTH + 1) / 2;

			logic [HW-1:0]   x_lo;
			logic [HW-1:0]   x_hi;
			logic [HW-1:0]   y_lo;
			logic [HW-1:0]   y_hi;
			logic [2*HW-1:0] pp_ll;
			logic [2*HW-1:0] pp_lh;
			logic [2*HW-1:0] pp_hl;
			logic [2*HW-1:0] pp_hh;

			assign x_lo = x[HW-1:0];
			assign x_hi = HW'(x[WIDTH-1:HW]);
			assign y_lo = y[HW-1:0];
			assign y_hi = HW'(y[WIDTH-1:HW]);

			mant_mul #(.WIDTH(HW)) mul_hl_i (.x(x_hi), .y(y_lo), .p(pp_hl));
			mant_mul #(.WIDTH(HW)) mul_ll_i (.x(x_lo), .y(y_lo), .p(pp_ll));
			mant_mul #(.WIDTH(HW)) mul_hh_i (.x(x_hi), .y(y_hi), .p(pp_hh));
			mant_mul #(.WIDTH(HW)) mul_lh_i (.x(x_lo), .y(y_hi), .p(pp_lh));

			// cross terms sit one half up, the high product two halves up
			assign p = (2*WIDTH)'(pp_ll)
				+ ((2*WIDTH)'(pp_hl) << HW)
				+ ((2*WIDTH)'(pp_lh) << HW)
				+ ((2*WIDTH)'(pp_hh) << (2*HW));
		end else begin : g_direct
			assign p = x * y;   // leaf block, small enough for a plain array multiplier
		end
	endgenerate

endmodule

// File: verilog/norm_pack.sv
`timescale 1ns/10ps
module norm_pack import fp_pkg::*; (
	input  logic [PROD_W-1:0] prod,
	input  exp_sum_t          sum,
	output mul_res_t          res
);
	logic                     norm_shift;
	logic [FRAC_W-1:0]        frac;
	logic signed [ESUM_W-1:0] exp_fin;

	// product of two values in [1,2) lies in [1,4), so at most one bit of shift
	assign norm_shift = prod[PROD_W-1];

	// bits below the kept fraction are dropped, which truncates toward zero
	assign frac = norm_shift ? prod[PROD_W-2 -: FRAC_W] : prod[PROD_W-3 -: FRAC_W];

	assign exp_fin = sum.exp + ESUM_W'(norm_shift);

	always_comb begin
		res.word.sign = sum.sign;
		res.word.exp  = exp_fin[EXP_W-1:0];
		res.word.frac = frac;
		res.ovf       = 1'b0;
		res.unf       = 1'b0;
		if (sum.zero) begin
			res.word.exp  = '0;   // signed zero, no flag
			res.word.frac = '0;
		end else if (exp_fin >= EXP_MAX) begin
			res.word.exp  = EXP_W'(EXP_MAX);
			res.word.frac = '0;
			res.ovf       = 1'b1;
		end else if (exp_fin <= 0) begin
			// no subnormal results, everything below the normal range goes to zero
			res.word.exp  = '0;
			res.word.frac = '0;
			res.unf       = 1'b1;
		end
	end

endmodule
